//--- src/sd_init_pkg.sv
// sd card init package with frame views, link structs, command indices and timing constants
package sd_init_pkg;

    // ==================================================
    // frame layout
    // ==================================================
    // field view of a 48-bit command or response
    typedef struct packed {
        logic        start;
        logic        trans;
        logic [5:0]  index;
        logic [31:0] arg;
        logic [6:0]  crc;
        logic        stop;
    } sd_fields_t;

    // raw view for the shifters, field view for the sequencer
    typedef union packed {
        logic [47:0] raw;
        sd_fields_t  f;
    } sd_frame_u;

    // response kinds
    localparam logic [1:0] resp_none  = 2'd0;
    localparam logic [1:0] resp_short = 2'd1;

    typedef struct packed {
        sd_frame_u  frame;
        logic [1:0] resp_kind;
    } sd_cmd_req_t;

    typedef struct packed {
        sd_frame_u frame;
        logic      timeout;
        logic      crc_bad;
    } sd_resp_t;

    // ==================================================
    // commands and arguments
    // ==================================================
    localparam logic [5:0]  cmd_go_idle  = 6'd0;
    localparam logic [5:0]  cmd_send_if  = 6'd8;
    localparam logic [5:0]  cmd_app      = 6'd55;
    localparam logic [5:0]  acmd_op_cond = 6'd41;
    // 2.7-3.6 V range, check pattern 0xaa
    localparam logic [31:0] if_cond_arg  = 32'h0000_01AA;
    // hcs set
    localparam logic [31:0] op_cond_arg  = 32'h4000_0000;

    // ==================================================
    // timing and sizes
    // ==================================================
    localparam int init_clocks     = 80;
    // small for sim, 250 on a 50 MHz board
    localparam int sd_clk_half     = 4;
    localparam int resp_timeout    = 64;
    localparam int op_cond_retries = 16;
    localparam int fifo_depth      = 4;

    // ==================================================
    // sequencer and phy state codes
    // ==================================================
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_cmd0   = 3'd1;
    localparam logic [2:0] st_cmd8   = 3'd2;
    localparam logic [2:0] st_cmd55  = 3'd3;
    localparam logic [2:0] st_acmd41 = 3'd4;
    localparam logic [2:0] st_wait   = 3'd5;
    localparam logic [2:0] st_final  = 3'd6;

    localparam logic [2:0] ph_init  = 3'd0;
    localparam logic [2:0] ph_idle  = 3'd1;
    localparam logic [2:0] ph_send  = 3'd2;
    localparam logic [2:0] ph_wait  = 3'd3;
    localparam logic [2:0] ph_recv  = 3'd4;
    localparam logic [2:0] ph_gap   = 3'd5;
    localparam logic [2:0] ph_check = 3'd6;

    // crc7, x^7 + x^3 + 1, msb first over 40 bits
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

endpackage

//--- src/sd_cmd_sequencer.sv
// sd init step machine that builds command frames, checks responses and logs progress
`timescale 1ns/100ps

module sd_cmd_sequencer (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    output sd_init_pkg::sd_cmd_req_t req,
    output logic                     req_valid,
    input  logic                     req_ready,
    input  sd_init_pkg::sd_resp_t    resp,
    input  logic                     resp_valid,
    output logic [7:0]               log_char,
    output logic                     log_valid,
    output logic                     init_done,
    output logic                     init_error
);
    import sd_init_pkg::*;

    logic [2:0]                         state;
    // index of the command whose response comes next
    logic [5:0]                         wait_idx;
    logic [$clog2(op_cond_retries)-1:0] retry_cnt;
    logic                               failed;
    logic                               link_err;
    logic                               echo_ok;

    // ==================================================
    // frame build
    // ==================================================
    always_comb begin
        req               = '0;
        req.frame.f.start = 1'b0;
        req.frame.f.trans = 1'b1;
        req.frame.f.stop  = 1'b1;
        req.resp_kind     = resp_short;
        case (state)
            st_cmd0: begin
                req.frame.f.index = cmd_go_idle;
                req.resp_kind     = resp_none;
            end
            st_cmd8: begin
                req.frame.f.index = cmd_send_if;
                req.frame.f.arg   = if_cond_arg;
            end
            // rca is zero before cmd3
            st_cmd55: req.frame.f.index = cmd_app;
            default: begin
                req.frame.f.index = acmd_op_cond;
                req.frame.f.arg   = op_cond_arg;
            end
        endcase
        // crc over start, trans, index and arg
        req.frame.f.crc = crc7(req.frame.raw[47:8]);
    end

    assign req_valid = (state == st_cmd0) || (state == st_cmd8) ||
                       (state == st_cmd55) || (state == st_acmd41);

    // response checks
    assign link_err = resp.timeout || resp.crc_bad;
    assign echo_ok  = (resp.frame.f.index == cmd_send_if) &&
                      (resp.frame.f.arg[11:0] == if_cond_arg[11:0]);

    // ==================================================
    // step machine
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= st_idle;
            wait_idx   <= cmd_go_idle;
            retry_cnt  <= '0;
            failed     <= 1'b0;
            log_char   <= 8'h00;
            log_valid  <= 1'b0;
            init_done  <= 1'b0;
            init_error <= 1'b0;
        end else begin
            log_valid <= 1'b0;
            case (state)
                // phy holds off cmd0 until the idle clocks are out
                st_idle: state <= st_cmd0;
                st_cmd0: if (req_ready) begin
                    wait_idx <= cmd_go_idle;
                    state    <= st_wait;
                end
                st_cmd8: if (req_ready) begin
                    wait_idx <= cmd_send_if;
                    state    <= st_wait;
                end
                // queue the pair back to back
                st_cmd55: if (req_ready) begin
                    wait_idx <= cmd_app;
                    state    <= st_acmd41;
                end
                st_acmd41: if (req_ready) begin
                    state <= st_wait;
                end
                st_wait: if (resp_valid) begin
                    log_valid <= 1'b1;
                    case (wait_idx)
                        cmd_go_idle: begin
                            log_char <= "0";
                            state    <= st_cmd8;
                        end
                        cmd_send_if: begin
                            log_char <= "8";
                            if (link_err || !echo_ok) begin
                                failed <= 1'b1;
                                state  <= st_final;
                            end else begin
                                state <= st_cmd55;
                            end
                        end
                        cmd_app: begin
                            log_char <= "5";
                            wait_idx <= acmd_op_cond;
                            if (link_err) begin
                                failed <= 1'b1;
                                state  <= st_final;
                            end
                        end
                        default: begin
                            log_char <= "A";
                            // ocr bit 31 clear means still busy
                            if (link_err) begin
                                failed <= 1'b1;
                                state  <= st_final;
                            end else if (resp.frame.f.arg[31]) begin
                                state <= st_final;
                            end else if (retry_cnt == op_cond_retries - 1) begin
                                failed <= 1'b1;
                                state  <= st_final;
                            end else begin
                                retry_cnt <= retry_cnt + 1'b1;
                                state     <= st_cmd55;
                            end
                        end
                    endcase
                end
                // one closing char, then hold
                st_final: if (!init_done && !init_error) begin
                    log_valid  <= 1'b1;
                    log_char   <= failed ? "E" : "D";
                    init_done  <= !failed;
                    init_error <= failed;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- src/sd_cmd_fifo.sv
// four-entry command request FIFO with valid/ready on both sides
`timescale 1ns/100ps

module sd_cmd_fifo (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  sd_init_pkg::sd_cmd_req_t d,
    input  logic                     d_valid,
    output logic                     d_ready,
    output sd_init_pkg::sd_cmd_req_t q,
    output logic                     q_valid,
    input  logic                     q_ready
);
    import sd_init_pkg::*;

    sd_cmd_req_t                       mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]     wr_ptr;
    logic [$clog2(fifo_depth)-1:0]     rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0]   count;
    logic                              push;
    logic                              pop;

    assign d_ready = (count != fifo_depth);
    assign q_valid = (count != 0);
    // head entry, visible the cycle after the write
    assign q       = mem[rd_ptr];
    assign push    = d_valid && d_ready;
    assign pop     = q_valid && q_ready;

    // pointers wrap on their own at a power-of-two depth
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[wr_ptr] <= d;
        end
    end

endmodule

//--- src/sd_cmd_phy.sv
// sd command line phy with clock divider, frame shifter and response capture
`timescale 1ns/100ps

module sd_cmd_phy (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  sd_init_pkg::sd_cmd_req_t q,
    input  logic                     q_valid,
    output logic                     q_ready,
    output sd_init_pkg::sd_resp_t    resp,
    output logic                     resp_valid,
    output logic                     sd_clk,
    output logic                     sd_cmd_out,
    output logic                     sd_cmd_oe,
    input  logic                     sd_cmd_in
);
    import sd_init_pkg::*;

    logic [$clog2(sd_clk_half)-1:0] div_cnt;
    logic                           tick;
    logic                           rise_stb;
    logic                           fall_stb;
    logic                           fall_d;
    logic [2:0]                     state;
    logic [5:0]                     bit_cnt;
    // shared by idle clocks, timeout and gap
    logic [7:0]                     clk_cnt;
    logic                           timed_out;
    logic                           tx_shift;
    logic                           rx_shift;
    logic [47:0]                    tx_sh;
    logic [47:0]                    rx_sh;
    logic [5:0]                     tx_idx;
    logic [1:0]                     tx_kind;

    // ==================================================
    // sd clock divider
    // ==================================================
    assign tick     = (div_cnt == sd_clk_half - 1);
    // strobes lead the actual sd_clk edge by one cycle
    assign rise_stb = tick && !sd_clk;
    assign fall_stb = tick && sd_clk;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
            fall_d  <= 1'b0;
        end else begin
            // one cycle past the falling edge
            fall_d <= fall_stb;
            if (tick) begin
                div_cnt <= '0;
                sd_clk  <= ~sd_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // line fsm
    // ==================================================
    assign q_ready  = (state == ph_idle);
    assign tx_shift = (state == ph_send) && fall_d && (bit_cnt != 6'd48);
    assign rx_shift = rise_stb && (((state == ph_wait) && !sd_cmd_in) || (state == ph_recv));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ph_init;
            bit_cnt    <= '0;
            clk_cnt    <= '0;
            timed_out  <= 1'b0;
            sd_cmd_oe  <= 1'b0;
            sd_cmd_out <= 1'b1;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                // line driven high for the power-up clocks
                ph_init: begin
                    sd_cmd_oe  <= 1'b1;
                    sd_cmd_out <= 1'b1;
                    if (rise_stb) begin
                        if (clk_cnt == init_clocks - 1) begin
                            clk_cnt <= '0;
                            state   <= ph_idle;
                        end else begin
                            clk_cnt <= clk_cnt + 1'b1;
                        end
                    end
                end
                ph_idle: if (q_valid) begin
                    bit_cnt   <= '0;
                    timed_out <= 1'b0;
                    state     <= ph_send;
                end
                ph_send: if (fall_d) begin
                    if (bit_cnt == 6'd48) begin
                        // end bit held through its rising edge, now release
                        sd_cmd_oe <= 1'b0;
                        clk_cnt   <= '0;
                        state     <= (tx_kind == resp_short) ? ph_wait : ph_gap;
                    end else begin
                        sd_cmd_oe  <= 1'b1;
                        sd_cmd_out <= tx_sh[47];
                        bit_cnt    <= bit_cnt + 1'b1;
                    end
                end
                // hunt for the start bit
                ph_wait: if (rise_stb) begin
                    if (!sd_cmd_in) begin
                        bit_cnt <= 6'd1;
                        state   <= ph_recv;
                    end else if (clk_cnt == resp_timeout - 1) begin
                        timed_out <= 1'b1;
                        state     <= ph_check;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ph_recv: if (rise_stb) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 6'd47) begin
                        state <= ph_check;
                    end
                end
                // no response, 8 clocks of settle
                ph_gap: if (rise_stb) begin
                    if (clk_cnt == 8'd7) begin
                        state <= ph_check;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ph_check: begin
                    resp_valid <= 1'b1;
                    state      <= ph_idle;
                end
                default: state <= ph_init;
            endcase
        end
    end

    // ==================================================
    // shift registers and response
    // ==================================================
    always_ff @(posedge CLOCK_50) begin
        if (q_valid && q_ready) begin
            tx_sh   <= q.frame.raw;
            tx_idx  <= q.frame.f.index;
            tx_kind <= q.resp_kind;
        end else if (tx_shift) begin
            tx_sh <= {tx_sh[46:0], 1'b1};
        end
        if (rx_shift) begin
            rx_sh <= {rx_sh[46:0], sd_cmd_in};
        end
        if (state == ph_check) begin
            resp.frame.raw <= (tx_kind == resp_short && !timed_out) ? rx_sh : '0;
            resp.timeout   <= timed_out;
            // r3 carries an all-ones crc field
            resp.crc_bad   <= (tx_kind == resp_short) && !timed_out &&
                              (tx_idx != acmd_op_cond) &&
                              (crc7(rx_sh[47:8]) != rx_sh[7:1]);
        end
    end

endmodule

//--- src/sd_init_top.sv
// sd card init top level joining sequencer, command FIFO and line phy
`timescale 1ns/100ps

module sd_init_top (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    output logic       sd_clk,
    output logic       sd_cmd_out,
    output logic       sd_cmd_oe,
    input  logic       sd_cmd_in,
    output logic [7:0] log_char,
    output logic       log_valid,
    output logic       init_done,
    output logic       init_error
);
    import sd_init_pkg::*;

    // sequencer to fifo
    sd_cmd_req_t req;
    logic        req_valid;
    logic        req_ready;
    // fifo to phy
    sd_cmd_req_t q;
    logic        q_valid;
    logic        q_ready;
    // phy back to sequencer
    sd_resp_t    resp;
    logic        resp_valid;

    sd_cmd_sequencer i_sd_cmd_sequencer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .log_char   (log_char),
        .log_valid  (log_valid),
        .init_done  (init_done),
        .init_error (init_error)
    );

    sd_cmd_fifo i_sd_cmd_fifo (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .d        (req),
        .d_valid  (req_valid),
        .d_ready  (req_ready),
        .q        (q),
        .q_valid  (q_valid),
        .q_ready  (q_ready)
    );

    // pad tristate lives on the board
    sd_cmd_phy i_sd_cmd_phy (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .q          (q),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in)
    );

endmodule

//--- sim/sd_init_sva.sv
// line protocol, fifo occupancy and status assertions for the sd init top level
`timescale 1ns/100ps

module sd_init_sva (
    input logic CLOCK_50,
    input logic KEY0,
    input logic sd_clk,
    input logic sd_cmd_out,
    input logic sd_cmd_oe,
    input logic sd_cmd_in,
    input logic push,
    input logic pop,
    input logic init_done,
    input logic init_error
);
    // shadow occupancy of the command FIFO
    logic [2:0] occ;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            occ <= 3'd0;
        end else begin
            occ <= occ + {2'b0, push} - {2'b0, pop};
        end
    end

    // command bit held across the high phase
    a_cmd_stable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (sd_clk && $past(sd_clk) && sd_cmd_oe && $past(sd_cmd_oe)) |-> $stable(sd_cmd_out))
        else $error("sd_cmd_out changed while sd_clk high");

    // card drives low only with the host released
    a_oe_low_rx: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !sd_cmd_in |-> !sd_cmd_oe)
        else $error("sd_cmd_oe high during response");

    a_no_push_full: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        push |-> (occ < 3'd4 || pop))
        else $error("FIFO push while full");

    a_done_xor_err: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(init_done && init_error))
        else $error("init_done and init_error both high");

endmodule

bind sd_init_top sd_init_sva i_sd_init_sva (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .sd_clk     (sd_clk),
    .sd_cmd_out (sd_cmd_out),
    .sd_cmd_oe  (sd_cmd_oe),
    .sd_cmd_in  (sd_cmd_in),
    .push       (req_valid && req_ready),
    .pop        (q_valid && q_ready),
    .init_done  (init_done),
    .init_error (init_error)
);

//--- sim/sd_card_model.sv
// behavioral sd card that checks command frames and drives command line responses
`timescale 1ns/100ps

module sd_card_model (
    input  logic KEY0,
    input  logic sd_clk,
    input  logic sd_cmd_out,
    input  logic sd_cmd_oe,
    output logic sd_cmd_in,
    input  int   busy_count,
    input  logic echo_ok,
    output int   frame_errs,
    output int   pair_cnt,
    output int   init_clks
);
    // seed for the response gap
    integer      seed = 4;
    int          rx_cnt;
    logic [47:0] rx_sh;
    logic        seen_frame;
    // 0 cmd0, 1 cmd8, 2 cmd55, 3 acmd41
    int          step;
    int          req_cnt;
    int          served;
    logic [47:0] resp_frame;
    logic [47:0] tx_sh;
    int          tx_bits;
    int          gap;

    // crc7 with x^7 + x^3 + 1, msb first
    function automatic logic [6:0] frame_crc(input logic [39:0] bits);
        logic [6:0] r;
        r = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            r = {r[5:0], 1'b0} ^ (((bits[i] ^ r[6]) == 1'b1) ? 7'b0001001 : 7'b0);
        end
        return r;
    endfunction

    function automatic logic [47:0] make_resp(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] head;
        head = {2'b00, idx, arg};
        return {head, frame_crc(head), 1'b1};
    endfunction

    // ==================================================
    // command receive, sampled on sd_clk rise
    // ==================================================
    always @(posedge sd_clk or negedge KEY0) begin : rx_blk
        logic [47:0] fr;
        logic [5:0]  exp_idx;
        logic [31:0] exp_arg;
        if (!KEY0) begin
            rx_cnt     <= 0;
            seen_frame <= 1'b0;
            init_clks  <= 0;
            step       <= 0;
            req_cnt    <= 0;
            pair_cnt   <= 0;
            frame_errs <= 0;
        end else if (sd_cmd_oe) begin
            if (rx_cnt == 0) begin
                if (!sd_cmd_out) begin
                    rx_sh      <= 48'd0;
                    rx_cnt     <= 1;
                    seen_frame <= 1'b1;
                end else if (!seen_frame) begin
                    init_clks <= init_clks + 1;
                end
            end else if (rx_cnt < 47) begin
                rx_sh  <= {rx_sh[46:0], sd_cmd_out};
                rx_cnt <= rx_cnt + 1;
            end else begin
                // last bit, frame complete
                fr      = {rx_sh[46:0], sd_cmd_out};
                rx_cnt  <= 0;
                exp_idx = (step == 0) ? 6'd0 : (step == 1) ? 6'd8 : (step == 2) ? 6'd55 : 6'd41;
                exp_arg = (step == 1) ? 32'h0000_01AA : (step == 3) ? 32'h4000_0000 : 32'h0;
                if (fr[47] !== 1'b0 || fr[46] !== 1'b1 || fr[0] !== 1'b1) begin
                    $display("ERROR frame framing bits wrong: frame=%h", fr);
                    frame_errs <= frame_errs + 1;
                end
                if (fr[7:1] !== frame_crc(fr[47:8])) begin
                    $display("ERROR frame crc: got=%h exp=%h", fr[7:1], frame_crc(fr[47:8]));
                    frame_errs <= frame_errs + 1;
                end
                if (fr[45:40] !== exp_idx || fr[39:8] !== exp_arg) begin
                    $display("ERROR frame index/arg: got=%h/%h exp=%h/%h",
                             fr[45:40], fr[39:8], exp_idx, exp_arg);
                    frame_errs <= frame_errs + 1;
                end
                case (step)
                    0: step <= 1;
                    1: begin
                        resp_frame <= make_resp(6'd8, echo_ok ? 32'h0000_01AA : 32'h0000_0155);
                        req_cnt    <= req_cnt + 1;
                        step       <= 2;
                    end
                    2: begin
                        // r1 with app_cmd status
                        resp_frame <= make_resp(6'd55, 32'h0000_0120);
                        req_cnt    <= req_cnt + 1;
                        step       <= 3;
                    end
                    default: begin
                        // r3, busy bit set once busy_count replies are out
                        resp_frame <= {2'b00, 6'h3F,
                                       (pair_cnt >= busy_count) ? 32'hC0FF_8000 : 32'h00FF_8000,
                                       7'h7F, 1'b1};
                        pair_cnt   <= pair_cnt + 1;
                        req_cnt    <= req_cnt + 1;
                        step       <= 2;
                    end
                endcase
            end
        end
    end

    // ==================================================
    // response drive, changes on sd_clk fall
    // ==================================================
    always @(negedge sd_clk or negedge KEY0) begin
        if (!KEY0) begin
            sd_cmd_in <= 1'b1;
            served    <= 0;
            tx_bits   <= 0;
            gap       <= 0;
        end else if (tx_bits != 0) begin
            sd_cmd_in <= tx_sh[47];
            tx_sh     <= {tx_sh[46:0], 1'b1};
            tx_bits   <= tx_bits - 1;
        end else if (gap != 0) begin
            sd_cmd_in <= 1'b1;
            gap       <= gap - 1;
            if (gap == 1) begin
                tx_bits <= 48;
            end
        end else begin
            sd_cmd_in <= 1'b1;
            if (served != req_cnt) begin
                served <= req_cnt;
                tx_sh  <= resp_frame;
                // 2 to 10 idle clocks
                gap    <= 2 + int'($unsigned($random(seed)) % 9);
            end
        end
    end

endmodule

//--- sim/tb_sd_init.sv
// testbench for the sd card init top level with a behavioral card and file driven tests
`timescale 1ns/100ps

module tb_sd_init;
    import sd_init_pkg::*;

    localparam int clk_period = 20;
    localparam int sd_period  = clk_period * 2 * sd_clk_half;

    logic       CLOCK_50 = 1'b0;
    logic       KEY0;
    logic       sd_clk;
    logic       sd_cmd_out;
    logic       sd_cmd_oe;
    logic       sd_cmd_in;
    logic [7:0] log_char;
    logic       log_valid;
    logic       init_done;
    logic       init_error;

    // card behavior per test
    int         busy_count;
    logic       echo_ok;
    int         frame_errs;
    int         pair_cnt;
    int         init_clks;

    int         busy_tab[$];
    logic       echo_tab[$];
    string      exp_tab[$];
    byte        got_q[$];
    int         n_tests = 0;
    int         errors  = 0;
    int         card_errs = 0;

    always #(clk_period / 2) CLOCK_50 = ~CLOCK_50;

    sd_init_top i_sd_init_top (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in),
        .log_char   (log_char),
        .log_valid  (log_valid),
        .init_done  (init_done),
        .init_error (init_error)
    );

    sd_card_model i_card (
        .KEY0       (KEY0),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in),
        .busy_count (busy_count),
        .echo_ok    (echo_ok),
        .frame_errs (frame_errs),
        .pair_cnt   (pair_cnt),
        .init_clks  (init_clks)
    );

    // progress characters
    always @(posedge CLOCK_50) begin
        if (log_valid) begin
            got_q.push_back(log_char);
        end
    end

    task automatic read_stimulus();
        int    fd;
        int    busy;
        int    echo;
        string line;
        string exp_s;
        fd = $fopen("sim/sd_init_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file could not be opened");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %s", busy, echo, exp_s) == 3) begin
                    busy_tab.push_back(busy);
                    echo_tab.push_back(echo != 0);
                    exp_tab.push_back(exp_s);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int idx);
        int   exp_pairs;
        logic exp_done;
        string exp_s;
        exp_s = exp_tab[idx];
        @(posedge CLOCK_50);
        KEY0       <= 1'b0;
        busy_count <= busy_tab[idx];
        echo_ok    <= echo_tab[idx];
        repeat (3) @(posedge CLOCK_50);
        got_q.delete();
        KEY0 <= 1'b1;
        while (!(init_done || init_error)) begin
            @(posedge CLOCK_50);
        end
        repeat (4) @(posedge CLOCK_50);

        // expected outcome from the init rules
        exp_done  = echo_tab[idx] && (busy_tab[idx] < op_cond_retries);
        exp_pairs = !echo_tab[idx] ? 0 :
                    (busy_tab[idx] < op_cond_retries) ? busy_tab[idx] + 1 : op_cond_retries;
        if (got_q.size() != exp_s.len()) begin
            $display("test %0d: got %0d progress chars, expected %0d",
                     idx, got_q.size(), exp_s.len());
            errors++;
        end else begin
            for (int i = 0; i < exp_s.len(); i++) begin
                if (got_q[i] != exp_s.getc(i)) begin
                    $display("ERROR log_char[%0d]: got=%h exp=%h", i, got_q[i], exp_s.getc(i));
                    errors++;
                end
            end
        end
        if (init_done !== exp_done) begin
            $display("ERROR init_done: got=%h exp=%h", init_done, exp_done);
            errors++;
        end
        if (init_error !== !exp_done) begin
            $display("ERROR init_error: got=%h exp=%h", init_error, !exp_done);
            errors++;
        end
        if (pair_cnt != exp_pairs) begin
            $display("ERROR pair_cnt: got=%h exp=%h", pair_cnt, exp_pairs);
            errors++;
        end
        if (init_clks < init_clocks) begin
            $display("ERROR init_clks: got=%h exp>=%h", init_clks, init_clocks);
            errors++;
        end
        card_errs += frame_errs;
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        // high until the first test pulls it low, so every reset is a real edge
        KEY0       = 1'b1;
        busy_count = 0;
        echo_ok    = 1'b1;
        read_stimulus();
        n_tests = busy_tab.size();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        errors += card_errs;
        $display("tests: %0d  errors: %0d  card frame errors: %0d", n_tests, errors, card_errs);
        if (errors == 0 && n_tests > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // worst case per test is the full retry run
    initial begin
        wait (n_tests != 0);
        #(n_tests * (op_cond_retries + 4) * 200 * sd_period);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- sim/sd_init_stimulus.txt
# busy_count cmd8_echo_ok expected_progress
# busy_count = ACMD41 replies with the busy bit clear before ready
0 1 085AD
1 1 085A5AD
3 1 085A5A5A5AD
15 1 085A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5AD
16 1 085A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5AE
0 0 08E

//--- sd_init.f
src/sd_init_pkg.sv
src/sd_cmd_sequencer.sv
src/sd_cmd_fifo.sv
src/sd_cmd_phy.sv
src/sd_init_top.sv
sim/sd_init_sva.sv
sim/sd_card_model.sv
sim/tb_sd_init.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_sd_init
FILELIST  := sd_init.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
